// File: Makefile
VERILATOR ?= verilator
TOP       ?= hackComputer_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/dataBus.sv
/*
    cpu to data ram link
    single cycle access, combinational read, clocked write
*/
interface dataBus import hackPkg::*; ();

    logic [ramAddrWidth-1:0] addr;      // low bits of A
    logic [wordWidth-1:0]    writeData; // alu result
    logic                    writeEn;   // store to M
    logic [wordWidth-1:0]    readData;  // M, pre-write content

    modport cpu (
        output addr,
        output writeData,
        output writeEn,
        input  readData
    );

    modport mem (
        input  addr,
        input  writeData,
        input  writeEn,
        output readData
    );

endinterface

// File: hw/dataRam.sv
/*
    data memory
    asynchronous read at bus address, write on the clock edge
*/
module dataRam import hackPkg::*; (
    input logic clk,
    dataBus.mem bus
);

    // contents not cleared by reset
    logic [wordWidth-1:0] words [0:(1 << ramAddrWidth) - 1];

    // store
    always_ff @(posedge clk) begin
        if (bus.writeEn) begin
            words[bus.addr] <= bus.writeData;
        end
    end

    // read shows old word until the edge
    assign bus.readData = words[bus.addr];

endmodule

// File: hw/hackAlu.sv
/*
    hack alu
    zero/negate controls on both inputs, add or and, optional output negate
*/
module hackAlu import hackPkg::*; (
    input  logic [wordWidth-1:0] x,        // D register
    input  logic [wordWidth-1:0] y,        // A or M
    input  aluOp                 op,
    output logic [wordWidth-1:0] result,
    output logic                 zero,     // result == 0
    output logic                 negative  // result < 0
);

    logic [5:0]           ctl;  // raw bits, so unnamed codes still decode
    logic [wordWidth-1:0] xZ;
    logic [wordWidth-1:0] xN;
    logic [wordWidth-1:0] yZ;
    logic [wordWidth-1:0] yN;
    logic [wordWidth-1:0] fOut;

    assign ctl = op;

    // x side
    assign xZ = ctl[5] ? '0 : x;   // zx
    assign xN = ctl[4] ? ~xZ : xZ; // nx

    // y side
    assign yZ = ctl[3] ? '0 : y;   // zy
    assign yN = ctl[2] ? ~yZ : yZ; // ny

    // function select, f=1 add, f=0 and
    always_comb begin
        if (ctl[1]) begin
            fOut = xN + yN; // carry out dropped
        end else begin
            fOut = xN & yN;
        end
    end

    assign result = ctl[0] ? ~fOut : fOut; // no

    // flags on final result
    assign zero     = (result == '0);
    assign negative = result[wordWidth-1];

endmodule

// File: hw/hackComputer.sv
/*
    hack computer top level
    rom, cpu and data ram, program load port and cpu state taps
*/
module hackComputer import hackPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    progWrite, // rom load, only under reset
    input  logic [romAddrWidth-1:0] progAddr,
    input  logic [wordWidth-1:0]    progData,
    output logic [romAddrWidth-1:0] pc,
    output logic                    memWriteEn,
    output logic [ramAddrWidth-1:0] memAddr,
    output logic [wordWidth-1:0]    memWriteData,
    output logic [wordWidth-1:0]    regA,
    output logic [wordWidth-1:0]    regD
);

    logic [wordWidth-1:0] instr; // fetched word

    dataBus bus ();

    instrRom romInst (
        .clk       (clk),
        .addr      (pc),
        .instr     (instr),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData)
    );

    hackCpu cpuInst (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .pc    (pc),
        .mem   (bus.cpu),
        .regA  (regA),
        .regD  (regD)
    );

    dataRam ramInst (
        .clk (clk),
        .bus (bus.mem)
    );

    // bus taps
    assign memWriteEn   = bus.writeEn;
    assign memAddr      = bus.addr;
    assign memWriteData = bus.writeData;

endmodule

// File: hw/hackCpu.sv
/*
    hack cpu, one instruction per clock
    decode, A/D registers, alu operand muxes, jump test and program counter
*/
module hackCpu import hackPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [wordWidth-1:0]    instr, // from rom at pc
    output logic [romAddrWidth-1:0] pc,
    dataBus.cpu                     mem,
    output logic [wordWidth-1:0]    regA,
    output logic [wordWidth-1:0]    regD
);

    // instruction layout
    // 1 x x a  c1 c2 c3 c4  c5 c6 d1 d2  d3 j1 j2 j3
    instrKind             kind;
    aluOp                 op;
    jumpCond              jump;
    logic                 isC;
    logic                 selM;  // a bit
    logic                 destA; // d1
    logic                 destD; // d2
    logic                 destM; // d3

    logic [wordWidth-1:0] yIn;
    logic [wordWidth-1:0] aluOut;
    logic                 aluZero;
    logic                 aluNeg;
    logic [wordWidth-1:0] aIn;
    logic                 loadA;
    logic                 condMet;
    logic                 takeJump;

    // decode
    assign kind = instrKind'(instr[15]);
    assign isC  = (kind == cInstr);
    assign selM = instr[12];
    assign op   = aluOp'(instr[11:6]);
    assign {destA, destD, destM} = instr[5:3];
    assign jump = jumpCond'(instr[2:0]);

    // y operand, A or M
    assign yIn = selM ? mem.readData : regA;

    hackAlu aluInst (
        .x        (regD),
        .y        (yIn),
        .op       (op),
        .result   (aluOut),
        .zero     (aluZero),
        .negative (aluNeg)
    );

    // A input: constant for A-instr, alu result otherwise
    assign aIn   = isC ? aluOut : instr; // bit 15 already clear for A-instr
    assign loadA = !isC || destA;

    // jump condition on alu flags
    always_comb begin
        case (jump)
            jNone:   condMet = 1'b0;
            jGt:     condMet = !aluZero && !aluNeg;
            jEq:     condMet = aluZero;
            jGe:     condMet = !aluNeg;
            jLt:     condMet = aluNeg;
            jNe:     condMet = !aluZero;
            jLe:     condMet = aluNeg || aluZero;
            jMp:     condMet = 1'b1;
            default: condMet = 1'b0;
        endcase
    end

    assign takeJump = isC && condMet; // A-instr never jumps

    // A, D and pc
    always_ff @(posedge clk) begin
        if (reset) begin
            regA <= '0;
            regD <= '0;
            pc   <= '0;
        end else begin
            if (loadA) begin
                regA <= aIn;
            end
            if (isC && destD) begin
                regD <= aluOut;
            end
            // load from A or step, wraps at rom depth
            pc <= takeJump ? regA[romAddrWidth-1:0] : pc + 1'b1;
        end
    end

    // data bus
    assign mem.addr      = regA[ramAddrWidth-1:0]; // wraps at ram depth
    assign mem.writeData = aluOut;
    assign mem.writeEn   = isC && destM && !reset; // no stores while in reset

endmodule

// File: hw/hackPkg.sv
/*
    hack computer shared definitions
    word and address widths, alu operation codes, jump conditions
*/
package hackPkg;

    localparam int wordWidth    = 16; // instruction, data and register width
    localparam int romAddrWidth = 8;  // 256 program words
    localparam int ramAddrWidth = 8;  // 256 data words

    // c1..c6 = zx nx zy ny f no, x is D, y is A or M
    typedef enum logic [5:0] {
        zero     = 6'b101010,
        one      = 6'b111111,
        minusOne = 6'b111010,
        passX    = 6'b001100,
        passY    = 6'b110000,
        notX     = 6'b001101,
        notY     = 6'b110001,
        negX     = 6'b001111,
        negY     = 6'b110011,
        incX     = 6'b011111,
        incY     = 6'b110111,
        decX     = 6'b001110,
        decY     = 6'b110010,
        xPlusY   = 6'b000010,
        xMinusY  = 6'b010011,
        yMinusX  = 6'b000111,
        xAndY    = 6'b000000,
        xOrY     = 6'b010101
    } aluOp;

    // j1..j3, tested on the alu result
    typedef enum logic [2:0] {
        jNone = 3'b000,
        jGt   = 3'b001, // out > 0
        jEq   = 3'b010, // out == 0
        jGe   = 3'b011, // out >= 0
        jLt   = 3'b100, // out < 0
        jNe   = 3'b101, // out != 0
        jLe   = 3'b110, // out <= 0
        jMp   = 3'b111  // unconditional
    } jumpCond;

    // from instruction bit 15
    typedef enum logic {
        aInstr = 1'b0,
        cInstr = 1'b1
    } instrKind;

endpackage

// File: hw/instrRom.sv
/*
    program memory
    combinational fetch, clocked load port used under reset
*/
module instrRom import hackPkg::*; (
    input  logic                    clk,
    input  logic [romAddrWidth-1:0] addr,      // pc
    output logic [wordWidth-1:0]    instr,
    input  logic                    progWrite, // load strobe
    input  logic [romAddrWidth-1:0] progAddr,
    input  logic [wordWidth-1:0]    progData
);

    logic [wordWidth-1:0] words [0:(1 << romAddrWidth) - 1]; // 256 words

    // load port
    always_ff @(posedge clk) begin
        if (progWrite) begin
            words[progAddr] <= progData;
        end
    end

    // fetch, same cycle as pc
    assign instr = words[addr];

endmodule

// File: tb.f
hw/hackPkg.sv
hw/dataBus.sv
hw/hackAlu.sv
hw/hackCpu.sv
hw/instrRom.sv
hw/dataRam.sv
hw/hackComputer.sv
tests/hackComputer_sva.sv
tests/hackComputer_tb.sv

// File: tests/hackComputer_sva.sv
/*
    cpu checks bound into hackCpu
    reset behavior and A-instruction register effects
*/
module hackComputer_sva import hackPkg::*; (
    input logic                    clk,
    input logic                    reset,
    input logic [wordWidth-1:0]    instr,
    input logic [romAddrWidth-1:0] pc,
    input logic [wordWidth-1:0]    regA,
    input logic [wordWidth-1:0]    regD,
    input logic                    writeEn
);

    // no stores while held in reset
    noWriteInReset: assert property (@(posedge clk) reset |-> !writeEn)
        else $error("data write issued during reset");

    pcClearedByReset: assert property (@(posedge clk) reset |=> pc == '0)
        else $error("pc not zero after a reset cycle");

    // A-instr loads A, leaves D alone
    aInstrLoadsA: assert property (@(posedge clk) disable iff (reset)
        instrKind'(instr[15]) == aInstr |=> regA == $past(instr) && regD == $past(regD))
        else $error("A-instruction did not load A or changed D");

endmodule

bind hackCpu hackComputer_sva cpuChecks (
    .clk     (clk),
    .reset   (reset),
    .instr   (instr),
    .pc      (pc),
    .regA    (regA),
    .regD    (regD),
    .writeEn (mem.writeEn)
);

// File: tests/hackComputer_tb.sv
/*
    hack computer testbench
    loads one mixed test program, then runs it against an instruction-set model
*/
module hackComputer_tb import hackPkg::*; ();

    localparam int loadCycles  = 256;
    localparam int resetCycles = 2;
    localparam int runCycles   = 600;
    localparam int cycleLimit  = loadCycles + resetCycles + runCycles + 100;
    localparam int loopBase    = 235;   // summing loop ends just below word 255
    localparam logic [7:0] sumAddr = 8'h40;
    localparam logic [7:0] cntAddr = 8'h41;
    localparam logic [7:0] scratch = 8'h30; // M operand for a=1 alu tests

    typedef struct packed {
        logic [7:0]  pc;
        logic [15:0] a;
        logic [15:0] d;
        logic        we;
        logic [7:0]  addr;
        logic [15:0] wdata;
        logic        badRead; // program read M before storing it
    } stepResult;

    logic        clk;
    logic        reset;
    logic        progWrite;
    logic [7:0]  progAddr;
    logic [15:0] progData;
    logic [7:0]  pc;
    logic        memWriteEn;
    logic [7:0]  memAddr;
    logic [15:0] memWriteData;
    logic [15:0] regA;
    logic [15:0] regD;

    // instruction-set model state
    logic [15:0] romModel [0:255];
    logic [15:0] ramModel [0:255];
    logic        ramWritten [0:255];
    logic [15:0] mA;
    logic [15:0] mD;
    logic [7:0]  mPc;
    logic [15:0] operands [0:4] = '{16'h0000, 16'h0001, 16'h7FFF, 16'h8000, 16'hFFFF};
    logic [5:0]  aluOps [0:17];
    stepResult   expected;
    int          wp;
    int          afterWrap;
    int          runCount = 0;
    int          cycleCount = 0;
    integer      seed = 32'hb817_4d8a;
    logic [15:0] lastSum = 16'h0000; // last store seen at sumAddr

    hackComputer dut_i (.*);

    function automatic logic [15:0] encodeA(input logic [15:0] v);
        return {1'b0, v[14:0]};
    endfunction

    // 111 a c1..c6 d1..d3 j1..j3
    function automatic logic [15:0] encodeC(input logic a, input logic [5:0] comp,
                                            input logic [2:0] dest, input logic [2:0] jmp);
        return {3'b111, a, comp, dest, jmp};
    endfunction

    task automatic emitWord(input logic [15:0] w);
        romModel[wp] = w;
        wp++;
    endtask

    // D = v in two words, negative values through !A
    task automatic setD(input logic [15:0] v);
        emitWord(encodeA(v[15] ? ~v : v));
        emitWord(encodeC(1'b0, v[15] ? notY : passY, 3'b010, jNone));
    endtask

    task automatic setA(input logic [15:0] v);
        emitWord(encodeA(v[15] ? ~v : v));
        if (v[15]) begin
            emitWord(encodeC(1'b0, notY, 3'b100, jNone)); // A = !A
        end
    endtask

    task automatic buildProgram();
        logic [31:0] rnd;
        logic [5:0]  jc;
        aluOps = '{zero, one, minusOne, passX, passY, notX, notY, negX, negY,
                   incX, incY, decX, decY, xPlusY, xMinusY, yMinusX, xAndY, xOrY};
        wp = 0;
        emitWord(encodeC(1'b0, passX, 3'b000, jNe)); // D;JNE, re-entry after pc wrap
        emitWord(encodeA({8'h00, scratch}));
        emitWord(encodeC(1'b0, minusOne, 3'b001, jNone));
        // every alu function stored to M, a alternating, A/D destinations cycling
        for (int i = 0; i < 18; i++) begin
            setD(operands[i % 5]);
            if (i % 2 == 0) begin
                setA(operands[(i + 2) % 5]);
                emitWord(encodeC(1'b0, aluOps[i], {2'((i / 2) % 4), 1'b1}, jNone));
            end else begin
                emitWord(encodeA({8'h00, scratch}));
                emitWord(encodeC(1'b1, aluOps[i], {2'((i / 2) % 4), 1'b1}, jNone));
            end
        end
        // each condition on zero, positive and negative results
        for (int j = 0; j < 8; j++) begin
            for (int k = 0; k < 3; k++) begin
                jc = (k == 0) ? zero : (k == 1) ? one : minusOne;
                emitWord(encodeA(16'(wp + 3)));
                emitWord(encodeC(1'b0, jc, 3'b000, 3'(j)));
                emitWord(encodeC(1'b0, incX, 3'b010, jNone)); // skipped when taken
            end
        end
        emitWord(encodeC(1'b0, one, 3'b010, jNone));  // D = 1 arms word 0
        emitWord(encodeA(16'd255));
        emitWord(encodeC(1'b0, zero, 3'b000, jMp));   // 255 then wraps to 0
        afterWrap = wp;
        // random section, window 0x20..0x27 stored first
        for (int k = 0; k < 8; k++) begin
            emitWord(encodeA(16'(8'h20 + k)));
            emitWord(encodeC(1'b0, xPlusY, 3'b001, jNone));
        end
        while (wp < loopBase - 1) begin
            rnd = $random(seed);
            emitWord(encodeA({1'b0, rnd[14:8], 5'b00100, rnd[2:0]})); // high bits random
            rnd = $random(seed);
            emitWord(encodeC(rnd[6], rnd[5:0], rnd[9:7], jNone));
        end
        if (wp < loopBase) begin
            rnd = $random(seed);
            emitWord(encodeA(rnd[15:0]));
        end
        // sum of 1..20 with the counter in RAM
        emitWord(encodeA({8'h00, sumAddr}));
        emitWord(encodeC(1'b0, zero, 3'b001, jNone));
        emitWord(encodeA({8'h00, cntAddr}));
        emitWord(encodeC(1'b0, one, 3'b001, jNone));
        emitWord(encodeA({8'h00, cntAddr}));          // loop top
        emitWord(encodeC(1'b1, passY, 3'b010, jNone));
        emitWord(encodeA(16'd21));
        emitWord(encodeC(1'b0, xMinusY, 3'b010, jNone));
        emitWord(encodeA(16'(loopBase + 18)));
        emitWord(encodeC(1'b0, passX, 3'b000, jEq)); // count hit 21
        emitWord(encodeA({8'h00, cntAddr}));
        emitWord(encodeC(1'b1, passY, 3'b010, jNone));
        emitWord(encodeA({8'h00, sumAddr}));
        emitWord(encodeC(1'b1, xPlusY, 3'b001, jNone)); // sum += count
        emitWord(encodeA({8'h00, cntAddr}));
        emitWord(encodeC(1'b1, incY, 3'b001, jNone));
        emitWord(encodeA(16'(loopBase + 4)));
        emitWord(encodeC(1'b0, zero, 3'b000, jMp));
        emitWord(encodeA(16'(loopBase + 18)));      // spins here to the end
        emitWord(encodeC(1'b0, zero, 3'b000, jMp));
        romModel[255] = encodeA(16'(afterWrap));
    endtask

    // hack alu controls applied in order
    function automatic logic [15:0] aluRef(input logic [15:0] x, input logic [15:0] y,
                                           input logic [5:0] c);
        logic [15:0] xs;
        logic [15:0] ys;
        logic [15:0] r;
        xs = c[5] ? 16'h0000 : x;
        xs = c[4] ? ~xs : xs;
        ys = c[3] ? 16'h0000 : y;
        ys = c[2] ? ~ys : ys;
        r = c[1] ? xs + ys : xs & ys;
        return c[0] ? ~r : r;
    endfunction

    // runs the word at mPc, returns what the DUT shows in that cycle
    function automatic stepResult stepModel();
        stepResult   s;
        logic [15:0] ins;
        logic [15:0] res;
        logic        take;
        ins       = romModel[mPc];
        s.pc      = mPc;
        s.a       = mA;
        s.d       = mD;
        s.addr    = mA[7:0];
        s.we      = 1'b0;
        s.wdata   = 16'h0000;
        s.badRead = 1'b0;
        if (!ins[15]) begin
            mA  = ins;
            mPc = mPc + 8'd1;
        end else begin
            s.badRead = ins[12] && !ramWritten[s.addr];
            res  = aluRef(mD, ins[12] ? ramModel[s.addr] : mA, ins[11:6]);
            take = |(ins[2:0] & {res[15], res == 16'h0000, !res[15] && res != 16'h0000});
            s.we    = ins[3];
            s.wdata = res;
            if (ins[3]) begin
                ramModel[s.addr]   = res;
                ramWritten[s.addr] = 1'b1;
            end
            if (ins[4]) begin
                mD = res;
            end
            mPc = take ? mA[7:0] : mPc + 8'd1; // jump target is the old A
            if (ins[5]) begin
                mA = res;
            end
        end
        return s;
    endfunction

    task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] want);
        assert (got === want) else begin
            $display("[FAIL] %s: got %h, expected %h", name, got, want);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // compare each executed instruction, then advance the model
    always @(posedge clk) begin
        if (!reset && runCount < runCycles) begin
            expected = stepModel();
            assert (!expected.badRead) else begin
                $display("test program reads RAM word %h before storing to it", expected.addr);
                $display("Done: errors found");
                $fatal(1);
            end
            checkValue("pc", {8'h00, pc}, {8'h00, expected.pc});
            checkValue("regA", regA, expected.a);
            checkValue("regD", regD, expected.d);
            checkValue("memWriteEn", {15'h0000, memWriteEn}, {15'h0000, expected.we});
            if (expected.we) begin
                checkValue("memAddr", {8'h00, memAddr}, {8'h00, expected.addr});
                checkValue("memWriteData", memWriteData, expected.wdata);
                if (memAddr == sumAddr) begin
                    lastSum = memWriteData;
                end
            end
            runCount++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Done: errors found");
            $fatal(1);
        end
    end

    initial begin
        reset     = 1'b1;
        progWrite = 1'b0;
        progAddr  = 8'h00;
        progData  = 16'h0000;
        buildProgram();
        for (int i = 0; i < 256; i++) begin
            ramWritten[i] = 1'b0; // RAM content unknown at start
        end
        mA  = 16'h0000;
        mD  = 16'h0000;
        mPc = 8'h00;
        for (int i = 0; i < loadCycles; i++) begin
            @(negedge clk);
            progWrite = 1'b1;
            progAddr  = 8'(i);
            progData  = romModel[i];
        end
        @(negedge clk);
        progWrite = 1'b0;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
        wait (runCount == runCycles);
        if (lastSum === 16'd210) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("[FAIL] sum: got %h, expected %h", lastSum, 16'd210);
            $display("Done: errors found");
            $fatal(1);
        end
    end

endmodule
